//--- src.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/decode_pkg.sv
rtl/decode_latch.sv
rtl/instr_classifier.sv
rtl/uop_encoder.sv
rtl/operand_select.sv
rtl/decode_stage.sv
testbench/tb_clock.sv
testbench/decode_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' src.f) rtl/decode_config.svh

run: obj_dir/Vdecode_tb
	./obj_dir/Vdecode_tb | tee sim.log
	grep -qx "NO ERRORS" sim.log

obj_dir/Vdecode_tb: src.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module decode_tb -f src.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- testbench/decode_tb.sv
module decode_tb
    import rv_isa_pkg::*;
    import decode_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        clear;
    logic        book;
    fetch_t      fetch;
    decode_out_t dec;

    logic [31:0] lfsr = 32'h2132_4319;
    logic [31:0] pc_next = 32'h0000_1000;
    int          errors = 0;
    int          err_mark = 0;
    int          test_no = 0;
    int          issued = 0;
    bit          timed_out = 1'b0;

    tb_clock clock_gen (
        .clk (clk),
        .rst (rst)
    );

    decode_stage uut (
        .clk   (clk),
        .rst   (rst),
        .fetch (fetch),
        .stall (stall),
        .clear (clear),
        .dec   (dec),
        .book  (book)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rt, rs, f3, rd, opc};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [6:0]  opcodes [11];
        logic [31:0] w;
        logic [1:0]  k;
        opcodes = '{7'h33, 7'h13, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h37, 7'h03, 7'h23, 7'h0f,
                    7'h73};
        w = take_bits(32);
        w[6:0] = opcodes[4'(take_bits(4) % 11)];
        k = 2'(take_bits(2));
        // steer funct7 toward the codes that split op and op_imm
        if (k != 2'd3 && w[6:0] inside {7'h33, 7'h13})
            w[31:25] = (k == 2'd0) ? 7'h00 : (k == 2'd1) ? 7'h20 : 7'h01;
        return w;
    endfunction

    function automatic fetch_t make_fetch(input logic [31:0] word);
        fetch_t f;
        f.instr = word;
        f.pc = pc_next;
        f.spec = take_bits(32);
        pc_next = pc_next + 32'd4;
        return f;
    endfunction

    // expected decode of one latched slot
    function automatic decode_out_t expect_dec(input fetch_t f);
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [11:0] i12;
        logic        known;
        logic        no_src;
        instr_fmt_e  fmt;
        decode_out_t d;
        opc = f.instr[6:0];
        f7 = f.instr[31:25];
        f3 = f.instr[14:12];
        i12 = f.instr[31:20];
        known = 1'b1;
        no_src = 1'b0;
        d = '0;
        d.pipe = xpip;
        d.uop = 6'h3f;
        fmt = (opc == 7'h23) ? fmt_s : (opc == 7'h63) ? fmt_b :
              (opc == 7'h17) ? fmt_u : (opc == 7'h6f) ? fmt_j :
              (opc inside {7'h13, 7'h67, 7'h37, 7'h03, 7'h0f, 7'h73}) ? fmt_i : fmt_r;
        if (opc inside {7'h37, 7'h03, 7'h23, 7'h0f})
            d.pipe = lpip;
        else if (opc == 7'h73)
            d.pipe = cpip;
        // micro-ops in octal as group then sub
        case (opc)
            7'h33: begin
                if (f7 == 7'h00)
                    d.uop = {3'd0, f3};
                else if (f7 == 7'h20)
                    d.uop = {3'd1, (f3 == 3'd0) ? 3'd4 : 3'd5};
                else if (f7 == 7'h01 && f3 < 3'd4)
                    d.uop = {3'd1, f3};
                else if (f7 == 7'h01) begin
                    d.pipe = dpip;
                    d.uop = {3'd0, f3};
                end else
                    known = 1'b0;
            end
            7'h13: d.uop = (f3 == 3'd5 && f7 == 7'h20) ? 6'o32 : {3'd2, f3};
            7'h17: d.uop = 6'o40;
            7'h6f: d.uop = 6'o41;
            7'h67: d.uop = 6'o42;
            7'h63: d.uop = {3'd3, f3};
            7'h37: d.uop = 6'o03;
            7'h03: d.uop = {3'd0, f3};
            7'h23: d.uop = {3'd1, f3};
            7'h0f: d.uop = {3'd2, f3};
            7'h73: begin
                no_src = (f3 == 3'd0) || (f3 > 3'd3);
                if (f3 == 3'd0)
                    d.uop = {3'd0, 2'b00, i12 == 12'd1};
                else
                    d.uop = {3'd1, f3};
            end
            default: known = 1'b0;
        endcase
        d.req_rt = known && (fmt == fmt_r || fmt == fmt_s || fmt == fmt_b);
        d.req_rs = d.req_rt || (known && fmt == fmt_i && !no_src);
        if (fmt != fmt_s && fmt != fmt_b)
            d.rd = f.instr[11:7];
        if (d.req_rs)
            d.rs = f.instr[19:15];
        if (d.req_rt)
            d.rt = f.instr[24:20];
        case (fmt)
            fmt_i: d.imm = d.req_rs ? 32'(i12) : 32'({i12, f.instr[19:15]});
            fmt_s: d.imm = 32'({f7, f.instr[11:7]});
            fmt_b: d.imm = 32'({f7, f.instr[11:7], 1'b0});
            fmt_u, fmt_j: d.imm = 32'(f.instr[31:12]);
            default: d.imm = '0;
        endcase
        d.pc = f.pc;
        d.spec = f.spec;
        return d;
    endfunction

    a_load: assert property (@(posedge clk)
        (!rst && !clear && !stall) |=> (book && dec == expect_dec($past(fetch))))
        else begin
            $display("ERROR %0t: dec %h book %b, not the decode of the previous fetch",
                     $time, $sampled(dec), $sampled(book));
            errors++;
        end

    a_clear: assert property (@(posedge clk)
        (rst || clear) |=> (!book && dec == expect_dec('0)))
        else begin
            $display("ERROR %0t: dec %h book %b after clear or reset",
                     $time, $sampled(dec), $sampled(book));
            errors++;
        end

    // stall freezes everything except book
    a_hold: assert property (@(posedge clk)
        (!rst && !clear && stall) |=> (book && $stable(dec)))
        else begin
            $display("ERROR %0t: dec %h book %b moved under stall",
                     $time, $sampled(dec), $sampled(book));
            errors++;
        end

    a_rt_rs: assert property (@(posedge clk) disable iff (rst)
        (!dec.req_rt || dec.req_rs))
        else begin
            $display("ERROR %0t: req_rt without req_rs", $time);
            errors++;
        end

    task automatic drive(input fetch_t f, input logic s, input logic c);
        fetch = f;
        stall = s;
        clear = c;
        @(posedge clk);
        #1;
    endtask

    task automatic issue(input logic [31:0] word);
        drive(make_fetch(word), 1'b0, 1'b0);
        issued++;
    endtask

    // rst changes just after a rising edge, so it is looked at mid-cycle
    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_book(input logic level);
        int n;
        n = 0;
        while (book !== level && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (book !== level) begin
            $display("timeout: book never reached %b", level);
            timed_out = 1'b1;
        end
    endtask

    // one idle edge so the last sample of the test gets checked
    task automatic end_test(input string name);
        drive('0, 1'b0, 1'b0);
        test_no++;
        $display("test %0d %s done, %0d errors", test_no, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        fetch = '0;
        stall = 1'b0;
        clear = 1'b0;
        wait_reset_release();
        if (!timed_out) begin
            wait_book(1'b0);
            wait_book(1'b1);
            end_test("reset");
            // add, sub, mul, div
            issue(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));
            issue(enc(7'h20, 5'd5, 5'd6, 3'd0, 5'd4, 7'h33));
            issue(enc(7'h01, 5'd8, 5'd9, 3'd0, 5'd7, 7'h33));
            issue(enc(7'h01, 5'd11, 5'd12, 3'd4, 5'd10, 7'h33));
            end_test("r-type");
            issue(enc(7'h09, 5'd3, 5'd6, 3'd0, 5'd5, 7'h13));
            issue(enc(7'h20, 5'd3, 5'd4, 3'd5, 5'd6, 7'h13));
            issue(enc(7'h01, 5'd4, 5'd2, 3'd2, 5'd12, 7'h03));
            issue(enc(7'h12, 5'd7, 5'd8, 3'd2, 5'd10, 7'h23));
            issue(enc(7'h05, 5'd3, 5'd4, 3'd1, 5'd22, 7'h63));
            issue({20'habcde, 5'd9, 7'h17});
            issue({20'h12345, 5'd1, 7'h6f});
            issue({12'h010, 5'd1, 3'd0, 5'd0, 7'h67});
            issue({20'h80000, 5'd2, 7'h37});
            issue(32'h0ff0_000f);
            issue(32'h0000_0073);
            issue(32'h0010_0073);
            issue({12'h300, 5'd10, 3'd1, 5'd11, 7'h73});
            issue({12'h305, 5'd17, 3'd5, 5'd0, 7'h73});  // csrrwi reads no register
            end_test("formats");
            issue(enc(7'h00, 5'd2, 5'd1, 3'd7, 5'd3, 7'h33));
            repeat (4) drive(make_fetch(random_instr()), 1'b1, 1'b0);
            issue(enc(7'h20, 5'd9, 5'd8, 3'd5, 5'd7, 7'h33));
            end_test("stall");
            issue(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33));
            // clear wins over a stall on the same edge
            drive(make_fetch(random_instr()), 1'b1, 1'b1);
            drive(make_fetch(random_instr()), 1'b0, 1'b1);
            issue({20'h00abc, 5'd5, 7'h37});
            wait_book(1'b1);
            end_test("clear");
            repeat (200) issue(random_instr());
            end_test("random");
        end
        $display("%0d tests, %0d instructions, %0d errors", test_no, issued, errors);
        if (errors == 0 && !timed_out)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset covers the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- rtl/decode_stage.sv
`include "decode_config.svh"

module decode_stage
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_t      fetch,
    input  logic        stall,
    input  logic        clear,
    output decode_out_t dec,
    output logic        book
);

    fetch_t            slot;
    instr_class_t      cls;
    instr_fmt_e        fmt;
    pipe_e             pipe;
    uop_t              uop;
    logic              req_rs;
    logic              req_rt;
    logic [`REG_W-1:0] rd;
    logic [`REG_W-1:0] rs;
    logic [`REG_W-1:0] rt;
    logic [`IMM_W-1:0] imm;

    decode_latch u_latch (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .clear (clear),
        .fetch (fetch),
        .slot  (slot),
        .book  (book)
    );

    instr_classifier u_classifier (
        .instr (slot.instr),
        .cls   (cls),
        .fmt   (fmt),
        .pipe  (pipe)
    );

    uop_encoder u_uop (
        .cls    (cls),
        .pipe   (pipe),
        .funct3 (slot.instr[`F3_LSB +: 3]),
        .funct7 (slot.instr[`F7_LSB +: 7]),
        .imm12  (slot.instr[`RT_LSB +: 12]),
        .uop    (uop)
    );

    operand_select u_operands (
        .cls    (cls),
        .fmt    (fmt),
        .instr  (slot.instr),
        .req_rs (req_rs),
        .req_rt (req_rt),
        .rd     (rd),
        .rs     (rs),
        .rt     (rt),
        .imm    (imm)
    );

    // pc and spec follow the latched word
    assign dec = '{pipe: pipe, uop: uop, req_rs: req_rs, req_rt: req_rt,
                   rd: rd, rs: rs, rt: rt, imm: imm, pc: slot.pc, spec: slot.spec};

endmodule

//--- rtl/operand_select.sv
`include "decode_config.svh"

module operand_select
    import rv_isa_pkg::*;
(
    input  instr_class_t       cls,
    input  instr_fmt_e         fmt,
    input  logic [`XLEN-1:0]   instr,
    output logic               req_rs,
    output logic               req_rt,
    output logic [`REG_W-1:0]  rd,
    output logic [`REG_W-1:0]  rs,
    output logic [`REG_W-1:0]  rt,
    output logic [`IMM_W-1:0]  imm
);

    logic [`REG_W-1:0] rd_f;
    logic [`REG_W-1:0] rs_f;
    logic [`REG_W-1:0] rt_f;
    logic [11:0]       imm12;
    logic [6:0]        imm7;
    logic [4:0]        imm5;
    logic [19:0]       imm20;
    logic              known;
    logic              two_src;

    assign rd_f  = instr[`RD_LSB +: `REG_W];
    assign rs_f  = instr[`RS_LSB +: `REG_W];
    assign rt_f  = instr[`RT_LSB +: `REG_W];
    assign imm12 = instr[`RT_LSB +: 12];
    assign imm7  = instr[`F7_LSB +: 7];
    assign imm5  = instr[`RD_LSB +: 5];
    assign imm20 = instr[`F3_LSB +: 20];

    // unrecognised words request nothing
    assign known   = |cls;
    assign two_src = known && (fmt == fmt_r || fmt == fmt_s || fmt == fmt_b);

    // ecall, ebreak and csr immediate forms have no register source
    assign req_rs = two_src || (known && fmt == fmt_i && !(cls.system && !cls.system_rs));
    assign req_rt = two_src;

    assign rd = (fmt == fmt_r || fmt == fmt_i || fmt == fmt_u || fmt == fmt_j) ? rd_f : '0;
    assign rs = req_rs ? rs_f : '0;
    assign rt = req_rt ? rt_f : '0;

    // raw fields, zero extended, no shifting
    always_comb begin
        case (fmt)
            fmt_i: begin
                if (req_rs)
                    imm = `IMM_W'(imm12);
                else
                    imm = `IMM_W'({imm12, rs_f});
            end
            fmt_s: imm = `IMM_W'({imm7, imm5});
            fmt_b: imm = `IMM_W'({imm7, imm5, 1'b0});
            fmt_u: imm = `IMM_W'(imm20);
            fmt_j: imm = `IMM_W'(imm20);
            default: imm = '0;
        endcase
    end

    always_comb begin
        a_rt_needs_rs: assert (!req_rt || req_rs);
    end

endmodule

//--- rtl/uop_encoder.sv
module uop_encoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  instr_class_t cls,
    input  pipe_e        pipe,
    input  logic [2:0]   funct3,
    input  logic [6:0]   funct7,
    input  logic [11:0]  imm12,
    output uop_t         uop
);

    always_comb begin
        // 0x3f marks a word no pipe understands
        uop = '{group: 3'd7, sub: 3'd7};
        case (pipe)
            xpip: begin
                if (cls.op_r && funct7 == 7'h00)
                    uop = '{group: 3'd0, sub: funct3};
                else if (cls.op_r && funct7 == 7'h20)
                    // sub or sra
                    uop = '{group: 3'd1, sub: (funct3 == 3'd0) ? 3'd4 : 3'd5};
                else if (cls.op_mul)
                    uop = '{group: 3'd1, sub: funct3};
                else if (cls.op_imm && funct3 == 3'd5 && funct7 == 7'h20)
                    // srai shares a code with the branch group
                    uop = '{group: 3'd3, sub: 3'd2};
                else if (cls.op_imm)
                    uop = '{group: 3'd2, sub: funct3};
                else if (cls.branch)
                    uop = '{group: 3'd3, sub: funct3};
                else if (cls.auipc)
                    uop = '{group: 3'd4, sub: 3'd0};
                else if (cls.jal)
                    uop = '{group: 3'd4, sub: 3'd1};
                else if (cls.jalr)
                    uop = '{group: 3'd4, sub: 3'd2};
            end
            dpip: begin
                uop = '{group: 3'd0, sub: funct3};
            end
            lpip: begin
                if (cls.load)
                    uop = '{group: 3'd0, sub: funct3};
                else if (cls.lui)
                    uop = '{group: 3'd0, sub: 3'd3};
                else if (cls.store)
                    uop = '{group: 3'd1, sub: funct3};
                else if (cls.misc_mem)
                    uop = '{group: 3'd2, sub: funct3};
            end
            cpip: begin
                // ecall is 0, ebreak is 1, csr ops keep funct3
                if (funct3 == 3'd0)
                    uop = '{group: 3'd0, sub: (imm12 == 12'd1) ? 3'd1 : 3'd0};
                else
                    uop = '{group: 3'd1, sub: funct3};
            end
            default: begin
                uop = '{group: 3'd7, sub: 3'd7};
            end
        endcase
    end

endmodule

//--- rtl/instr_classifier.sv
`include "decode_config.svh"

module instr_classifier
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic [`XLEN-1:0] instr,
    output instr_class_t     cls,
    output instr_fmt_e       fmt,
    output pipe_e            pipe
);

    opcode_e    opc;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opc    = opcode_e'(instr[`OPC_W-1:0]);
    assign funct3 = instr[`F3_LSB +: 3];
    assign funct7 = instr[`F7_LSB +: 7];

    always_comb begin
        cls = '0;
        // op splits on funct7 into add group, multiply and divide
        cls.op_r      = (opc == opc_op) && (funct7 == 7'h00 || funct7 == 7'h20);
        cls.op_mul    = (opc == opc_op) && (funct7 == 7'h01) && (funct3 < 3'd4);
        cls.op_div    = (opc == opc_op) && (funct7 == 7'h01) && (funct3 >= 3'd4);
        cls.op_imm    = (opc == opc_op_imm);
        cls.auipc     = (opc == opc_auipc);
        cls.jal       = (opc == opc_jal);
        cls.jalr      = (opc == opc_jalr);
        cls.branch    = (opc == opc_branch);
        cls.lui       = (opc == opc_lui);
        cls.load      = (opc == opc_load);
        cls.store     = (opc == opc_store);
        cls.misc_mem  = (opc == opc_misc_mem);
        cls.system    = (opc == opc_system);
        // csr ops with a register source
        cls.system_rs = cls.system && (funct3 >= 3'd1) && (funct3 <= 3'd3);
    end

    always_comb begin
        if (cls.op_r || cls.op_mul || cls.op_div)
            fmt = fmt_r;
        else if (cls.op_imm || cls.jalr || cls.lui || cls.load || cls.misc_mem || cls.system)
            fmt = fmt_i;
        else if (cls.store)
            fmt = fmt_s;
        else if (cls.branch)
            fmt = fmt_b;
        else if (cls.auipc)
            fmt = fmt_u;
        else if (cls.jal)
            fmt = fmt_j;
        else
            fmt = fmt_r;
    end

    // unknown words fall through to the alu pipe
    always_comb begin
        if (cls.op_r || cls.op_mul || cls.op_imm || cls.auipc || cls.jal || cls.jalr
            || cls.branch)
            pipe = xpip;
        else if (cls.op_div)
            pipe = dpip;
        else if (cls.lui || cls.load || cls.store || cls.misc_mem)
            pipe = lpip;
        else if (cls.system)
            pipe = cpip;
        else
            pipe = xpip;
    end

    always_comb begin
        a_one_class: assert ($onehot0({cls.op_r, cls.op_mul, cls.op_div, cls.op_imm,
                                       cls.auipc, cls.jal, cls.jalr, cls.branch,
                                       cls.lui, cls.load, cls.store, cls.misc_mem,
                                       cls.system}));
    end

endmodule

//--- rtl/decode_latch.sv
module decode_latch
    import decode_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   stall,
    input  logic   clear,
    input  fetch_t fetch,
    output fetch_t slot,
    output logic   book
);

    // clear wins over stall, stall only freezes the slot
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            slot <= '0;
            book <= 1'b0;
        end else if (stall) begin
            book <= 1'b1;
        end else begin
            slot <= fetch;
            book <= 1'b1;
        end
    end

    // a cleared slot is empty and unbooked on the next cycle
    a_clear_empties: assert property (
        @(posedge clk) clear |=> (!book && slot == '0)
    );

endmodule

//--- rtl/decode_pkg.sv
`include "decode_config.svh"

package decode_pkg;

    // execution pipe selection
    typedef enum logic [2:0] {
        xpip = 3'd0,
        dpip = 3'd1,
        lpip = 3'd2,
        cpip = 3'd3
    } pipe_e;

    // micro-op split into group and sub-op
    typedef struct packed {
        logic [`UOP_W/2-1:0] group;
        logic [`UOP_W/2-1:0] sub;
    } uop_t;

    // one fetched slot
    typedef struct packed {
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] spec;
    } fetch_t;

    typedef struct packed {
        pipe_e              pipe;
        uop_t               uop;
        logic               req_rs;
        logic               req_rt;
        logic [`REG_W-1:0]  rd;
        logic [`REG_W-1:0]  rs;
        logic [`REG_W-1:0]  rt;
        logic [`IMM_W-1:0]  imm;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   spec;
    } decode_out_t;

endpackage

//--- rtl/rv_isa_pkg.sv
`include "decode_config.svh"

package rv_isa_pkg;

    // base opcodes, bits [6:0] of the word
    typedef enum logic [`OPC_W-1:0] {
        opc_op       = 7'b01_100_11,
        opc_op_imm   = 7'b00_100_11,
        opc_auipc    = 7'b00_101_11,
        opc_jal      = 7'b11_011_11,
        opc_jalr     = 7'b11_001_11,
        opc_branch   = 7'b11_000_11,
        opc_lui      = 7'b01_101_11,
        opc_load     = 7'b00_000_11,
        opc_store    = 7'b01_000_11,
        opc_misc_mem = 7'b00_011_11,
        opc_system   = 7'b11_100_11
    } opcode_e;

    typedef enum logic [2:0] {
        fmt_r = 3'd0,
        fmt_i = 3'd1,
        fmt_s = 3'd2,
        fmt_b = 3'd3,
        fmt_u = 3'd4,
        fmt_j = 3'd5
    } instr_fmt_e;

    // one flag per class, system_rs rides along with system
    typedef struct packed {
        logic op_r;
        logic op_mul;
        logic op_div;
        logic op_imm;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic lui;
        logic load;
        logic store;
        logic misc_mem;
        logic system;
        logic system_rs;
    } instr_class_t;

endpackage

//--- rtl/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// architectural register address width
`define REG_W 5

// pc, spec and instruction word width
`define XLEN 32

// major opcode and micro-op widths
`define OPC_W 7
`define UOP_W 6

// immediate as handed to the execute pipes
`define IMM_W 32

// start bits of the instruction fields
`define RD_LSB 7
`define F3_LSB 12
`define RS_LSB 15
`define RT_LSB 20
`define F7_LSB 25

`endif
